/* include/hpi_axi_macros.svh */
//--------------------------------------------------------------------
// Widths and register map of the host-to-AXI bridge.
// The block ID sits in cpu_addr[23:12] and the offset in cpu_addr[11:0].
// HPI_US_CYCLES assumes a 100 MHz aclk.
//--------------------------------------------------------------------
`ifndef HPI_AXI_MACROS_SVH
`define HPI_AXI_MACROS_SVH

// Host register port
`define HPI_ADDR_W       24
`define HPI_DATA_W       32
`define HPI_BLOCK_ID     12'h018

// Register offsets within the block
`define HPI_OFS_CMD        12'h000
`define HPI_OFS_ADDR       12'h001
`define HPI_OFS_WDATA      12'h002
`define HPI_OFS_RDATA      12'h003
`define HPI_OFS_TMOUT_CFG  12'h004
`define HPI_OFS_TMOUT_ERR  12'h080
`define HPI_OFS_STATUS_ERR 12'h081
`define HPI_OFS_STATUS     12'h100

// AXI bus, one 64-byte beat per transfer
`define AXI_ADDR_W       64
`define AXI_DATA_W       512
`define AXI_BEAT_SHIFT   6

// Timeout monitors
`define HPI_US_CYCLES    100
`define TMOUT_CFG_W      16
`define TMOUT_RESET_US   16'hFFFF
`define N_CHAN           5
`define STATUS_W         10

`endif

/* rtl/hpi_reg_pkg.sv */
//--------------------------------------------------------------------
// Register-side types of the bridge.
// Command codes 1 is reserved and decodes as idle.
//--------------------------------------------------------------------
`include "hpi_axi_macros.svh"

package hpi_reg_pkg;

  typedef logic [`HPI_DATA_W-1:0] reg_word_t;

  // Offsets of the registers inside the 4K block window
  typedef enum logic [11:0] {
    REG_CMD        = `HPI_OFS_CMD,
    REG_ADDR       = `HPI_OFS_ADDR,
    REG_WDATA      = `HPI_OFS_WDATA,
    REG_RDATA      = `HPI_OFS_RDATA,
    REG_TMOUT_CFG  = `HPI_OFS_TMOUT_CFG,
    REG_TMOUT_ERR  = `HPI_OFS_TMOUT_ERR,
    REG_STATUS_ERR = `HPI_OFS_STATUS_ERR,
    REG_STATUS     = `HPI_OFS_STATUS
  } reg_offset_e;

  typedef enum logic [1:0] {
    CMD_IDLE  = 2'd0,
    CMD_READ  = 2'd2,
    CMD_WRITE = 2'd3
  } ddr_cmd_e;

endpackage

/* rtl/axi_chan_pkg.sv */
//--------------------------------------------------------------------
// Bus-side types of the bridge.
// Channel indices select bits of the monitor valid and ready vectors.
//--------------------------------------------------------------------
`include "hpi_axi_macros.svh"

package axi_chan_pkg;

  typedef enum logic [2:0] {
    CH_AW = 3'd0,
    CH_W  = 3'd1,
    CH_AR = 3'd2,
    CH_R  = 3'd3,
    CH_B  = 3'd4
  } axi_chan_e;

  typedef enum logic [1:0] {
    RESP_OKAY   = 2'b00,
    RESP_EXOKAY = 2'b01,
    RESP_SLVERR = 2'b10,
    RESP_DECERR = 2'b11
  } axi_resp_e;

  typedef logic [`AXI_ADDR_W-1:0] axi_addr_t;
  typedef logic [`AXI_DATA_W-1:0] axi_data_t;

endpackage

/* rtl/chan_timeout_mon.sv */
//--------------------------------------------------------------------
// Stall monitor for one AXI channel. A limit of 0 disables it.
// The count saturates at the limit, so one stall gives one pulse.
//--------------------------------------------------------------------
`include "hpi_axi_macros.svh"

module chan_timeout_mon (
  input  logic                    aclk,
  input  logic                    areset,
  input  logic                    valid,
  input  logic                    ready,
  input  logic [`TMOUT_CFG_W-1:0] tmout_us,
  output logic                    tmout
);

  localparam int PRE_W = $clog2(`HPI_US_CYCLES);

  logic                    stall;
  logic                    tick;
  logic [PRE_W-1:0]        pre_cnt;
  logic [`TMOUT_CFG_W-1:0] us_cnt;

  // Waiting means valid is up and the other side has not taken it yet
  assign stall = valid && !ready;
  assign tick  = stall && (pre_cnt == PRE_W'(`HPI_US_CYCLES - 1));

  always_ff @(posedge aclk or posedge areset) begin
    if (areset) begin
      pre_cnt <= '0;
      us_cnt  <= '0;
      tmout   <= 1'b0;
    end else if (!stall) begin
      pre_cnt <= '0;
      us_cnt  <= '0;
      tmout   <= 1'b0;
    end else begin
      pre_cnt <= tick ? '0 : pre_cnt + 1'b1;
      tmout   <= tick && (us_cnt + 1'b1 == tmout_us);
      if (tick && us_cnt != tmout_us) begin
        us_cnt <= us_cnt + 1'b1;
      end
    end
  end

endmodule

/* rtl/hpi_reg_bank.sv */
//--------------------------------------------------------------------
// Host register bank. Writes always cover the full word.
// Reads return the selected register one cycle after the address.
// Foreign block IDs and unmapped offsets read as 0.
//--------------------------------------------------------------------
`include "hpi_axi_macros.svh"

module hpi_reg_bank
  import hpi_reg_pkg::*;
(
  input  logic                    aclk,
  input  logic                    areset,
  input  logic                    cpu_wr,
  input  logic [`HPI_ADDR_W-1:0]  cpu_addr,
  input  reg_word_t               cpu_data_in,
  output reg_word_t               cpu_data_out,
  output ddr_cmd_e                cmd,
  output reg_word_t               ddr_addr,
  output reg_word_t               ddr_wdata,
  input  logic                    cmd_done,
  input  reg_word_t               ddr_rdata,
  output logic [`TMOUT_CFG_W-1:0] tmout_us,
  input  logic [`N_CHAN-1:0]      chan_tmout,
  input  logic [`STATUS_W-1:0]    hs_status
);

  logic                 block_sel;
  reg_offset_e          offset;
  logic                 wr_hit;
  logic [`N_CHAN-1:0]   tmout_q;
  logic [`N_CHAN-1:0]   tmout_err;
  logic [`N_CHAN-1:0]   tmout_clr;
  logic [`STATUS_W-1:0] status_q;
  logic [`STATUS_W-1:0] status_err;
  logic [`STATUS_W-1:0] status_clr;

  // Code 1 has no meaning and is taken as idle
  function automatic ddr_cmd_e cmd_decode(logic [1:0] code);
    if (code == CMD_READ) return CMD_READ;
    if (code == CMD_WRITE) return CMD_WRITE;
    return CMD_IDLE;
  endfunction

  assign block_sel = (cpu_addr[`HPI_ADDR_W-1 -: 12] == `HPI_BLOCK_ID);
  assign offset    = reg_offset_e'(cpu_addr[11:0]);
  assign wr_hit    = cpu_wr && block_sel;

  assign tmout_clr  = (wr_hit && offset == REG_TMOUT_ERR) ?
                      cpu_data_in[`N_CHAN-1:0] : '0;
  assign status_clr = (wr_hit && offset == REG_STATUS_ERR) ?
                      cpu_data_in[`STATUS_W-1:0] : '0;

  //------------------------------------------------------------------
  // Control registers
  //------------------------------------------------------------------
  always_ff @(posedge aclk or posedge areset) begin
    if (areset) begin
      cmd       <= CMD_IDLE;
      ddr_addr  <= '0;
      ddr_wdata <= '0;
      tmout_us  <= `TMOUT_RESET_US;
    end else begin
      if (cmd_done) begin
        cmd <= CMD_IDLE;
      end
      // A host write in the same cycle overrides the completion clear
      if (wr_hit) begin
        case (offset)
          REG_CMD:       cmd       <= cmd_decode(cpu_data_in[1:0]);
          REG_ADDR:      ddr_addr  <= cpu_data_in;
          REG_WDATA:     ddr_wdata <= cpu_data_in;
          REG_TMOUT_CFG: tmout_us  <= cpu_data_in[`TMOUT_CFG_W-1:0];
          default: ;
        endcase
      end
    end
  end

  //------------------------------------------------------------------
  // Status snapshot and sticky error registers
  //------------------------------------------------------------------
  always_ff @(posedge aclk or posedge areset) begin
    if (areset) begin
      tmout_q    <= '0;
      tmout_err  <= '0;
      status_q   <= '0;
      status_err <= '0;
    end else begin
      tmout_q    <= chan_tmout;
      status_q   <= hs_status;
      // The clear mask wins over flags arriving in the same cycle
      tmout_err  <= (tmout_err | tmout_q) & ~tmout_clr;
      status_err <= (status_err | status_q) & ~status_clr;
    end
  end

  // Registered read mux
  always_ff @(posedge aclk or posedge areset) begin
    if (areset) begin
      cpu_data_out <= '0;
    end else if (!block_sel) begin
      cpu_data_out <= '0;
    end else begin
      case (offset)
        REG_CMD:        cpu_data_out <= reg_word_t'(cmd);
        REG_ADDR:       cpu_data_out <= ddr_addr;
        REG_WDATA:      cpu_data_out <= ddr_wdata;
        REG_RDATA:      cpu_data_out <= ddr_rdata;
        REG_TMOUT_CFG:  cpu_data_out <= reg_word_t'(tmout_us);
        REG_TMOUT_ERR:  cpu_data_out <= reg_word_t'(tmout_err);
        REG_STATUS_ERR: cpu_data_out <= reg_word_t'(status_err);
        REG_STATUS:     cpu_data_out <= reg_word_t'(status_q);
        default:        cpu_data_out <= '0;
      endcase
    end
  end

endmodule

/* rtl/axi_single_master.sv */
//--------------------------------------------------------------------
// Single-beat AXI4 master. One 64-byte beat per command, full strobes.
// A new transfer starts on the rising edge of a command level only.
// Each valid drops on the first cycle its ready is high.
//--------------------------------------------------------------------
`include "hpi_axi_macros.svh"

module axi_single_master
  import hpi_reg_pkg::*;
  import axi_chan_pkg::*;
(
  input  logic                 aclk,
  input  logic                 areset,
  input  ddr_cmd_e             cmd,
  input  reg_word_t            ddr_addr,
  input  reg_word_t            ddr_wdata,
  output logic                 cmd_done,
  output reg_word_t            ddr_rdata,
  output axi_addr_t            awaddr,
  output logic [7:0]           awlen,
  output logic [2:0]           awsize,
  output logic                 awvalid,
  input  logic                 awready,
  output axi_data_t            wdata,
  output logic [63:0]          wstrb,
  output logic                 wlast,
  output logic                 wvalid,
  input  logic                 wready,
  input  axi_resp_e            bresp,
  input  logic                 bvalid,
  output logic                 bready,
  output axi_addr_t            araddr,
  output logic [7:0]           arlen,
  output logic [2:0]           arsize,
  output logic                 arvalid,
  input  logic                 arready,
  input  axi_data_t            rdata,
  input  axi_resp_e            rresp,
  input  logic                 rlast,
  input  logic                 rvalid,
  output logic                 rready,
  output logic [`N_CHAN-1:0]   chan_valid,
  output logic [`N_CHAN-1:0]   chan_ready,
  output logic [`STATUS_W-1:0] hs_status
);

  logic wr_cmd_d;
  logic rd_cmd_d;
  logic wr_start;
  logic wr_start_d;
  logic rd_start;
  logic aw_hs;
  logic ar_hs;

  assign wr_start = (cmd == CMD_WRITE) && !wr_cmd_d;
  assign rd_start = (cmd == CMD_READ) && !rd_cmd_d;
  assign aw_hs    = awvalid && awready;
  assign ar_hs    = arvalid && arready;
  assign cmd_done = (bvalid && bready) || (rvalid && rready && rlast);

  // Fixed single-beat burst attributes
  assign awlen  = 8'd0;
  assign arlen  = 8'd0;
  assign awsize = 3'(`AXI_BEAT_SHIFT);
  assign arsize = 3'(`AXI_BEAT_SHIFT);
  assign wstrb  = '1;
  assign wlast  = 1'b1;
  assign wdata  = axi_data_t'(ddr_wdata);

  always_ff @(posedge aclk) begin
    awaddr <= axi_addr_t'(ddr_addr) << `AXI_BEAT_SHIFT;
    araddr <= axi_addr_t'(ddr_addr) << `AXI_BEAT_SHIFT;
    if (rvalid && rready) begin
      ddr_rdata <= rdata[`HPI_DATA_W-1:0];
    end
  end

  //------------------------------------------------------------------
  // Request channels, W follows AW by one cycle
  //------------------------------------------------------------------
  always_ff @(posedge aclk or posedge areset) begin
    if (areset) begin
      wr_cmd_d   <= 1'b0;
      rd_cmd_d   <= 1'b0;
      wr_start_d <= 1'b0;
      awvalid    <= 1'b0;
      wvalid     <= 1'b0;
      arvalid    <= 1'b0;
    end else begin
      wr_cmd_d   <= (cmd == CMD_WRITE);
      rd_cmd_d   <= (cmd == CMD_READ);
      wr_start_d <= wr_start;
      if (wr_start) awvalid <= 1'b1;
      else if (awready) awvalid <= 1'b0;
      if (wr_start_d) wvalid <= 1'b1;
      else if (wready) wvalid <= 1'b0;
      if (rd_start) arvalid <= 1'b1;
      else if (arready) arvalid <= 1'b0;
    end
  end

  // Response windows reopen with the next address handshake
  always_ff @(posedge aclk or posedge areset) begin
    if (areset) begin
      bready <= 1'b1;
      rready <= 1'b1;
    end else begin
      if (aw_hs) bready <= 1'b1;
      else if (bvalid && bresp == RESP_OKAY) bready <= 1'b0;
      if (ar_hs) rready <= 1'b1;
      else if (rvalid && rresp == RESP_OKAY) rready <= 1'b0;
    end
  end

  assign chan_valid[CH_AW] = awvalid;
  assign chan_ready[CH_AW] = awready;
  assign chan_valid[CH_W]  = wvalid;
  assign chan_ready[CH_W]  = wready;
  assign chan_valid[CH_AR] = arvalid;
  assign chan_ready[CH_AR] = arready;
  assign chan_valid[CH_R]  = rvalid;
  assign chan_ready[CH_R]  = rready;
  assign chan_valid[CH_B]  = bvalid;
  assign chan_ready[CH_B]  = bready;

  assign hs_status = {rvalid, arvalid, bvalid, bready, wvalid,
                      awvalid, awready, wready, arready, rready};

endmodule

/* rtl/hpi2axi_bridge.sv */
//--------------------------------------------------------------------
// Host register port to AXI4 master bridge, single-beat transfers.
// Byte strobes on the host side are ignored.
// No AXI IDs are driven or checked.
//--------------------------------------------------------------------
`include "hpi_axi_macros.svh"

module hpi2axi_bridge
  import hpi_reg_pkg::*;
  import axi_chan_pkg::*;
(
  input  logic                      aclk,
  input  logic                      areset,
  // Host register port
  input  logic                      cpu_wr,
  input  logic [`HPI_ADDR_W-1:0]    cpu_addr,
  input  logic [`HPI_DATA_W/8-1:0]  cpu_wr_strb,
  input  reg_word_t                 cpu_data_in,
  output reg_word_t                 cpu_data_out,
  // AXI write
  output axi_addr_t                 awaddr,
  output logic [7:0]                awlen,
  output logic [2:0]                awsize,
  output logic                      awvalid,
  input  logic                      awready,
  output axi_data_t                 wdata,
  output logic [63:0]               wstrb,
  output logic                      wlast,
  output logic                      wvalid,
  input  logic                      wready,
  input  axi_resp_e                 bresp,
  input  logic                      bvalid,
  output logic                      bready,
  // AXI read
  output axi_addr_t                 araddr,
  output logic [7:0]                arlen,
  output logic [2:0]                arsize,
  output logic                      arvalid,
  input  logic                      arready,
  input  axi_data_t                 rdata,
  input  axi_resp_e                 rresp,
  input  logic                      rlast,
  input  logic                      rvalid,
  output logic                      rready
);

  ddr_cmd_e                cmd;
  reg_word_t               ddr_addr;
  reg_word_t               ddr_wdata;
  reg_word_t               ddr_rdata;
  logic                    cmd_done;
  logic [`TMOUT_CFG_W-1:0] tmout_us;
  logic [`N_CHAN-1:0]      chan_valid;
  logic [`N_CHAN-1:0]      chan_ready;
  logic [`N_CHAN-1:0]      chan_tmout;
  logic [`STATUS_W-1:0]    hs_status;

  hpi_reg_bank reg_bank_i (
    .aclk, .areset,
    .cpu_wr, .cpu_addr, .cpu_data_in, .cpu_data_out,
    .cmd, .ddr_addr, .ddr_wdata, .cmd_done, .ddr_rdata,
    .tmout_us, .chan_tmout, .hs_status
  );

  axi_single_master axi_master_i (
    .aclk, .areset,
    .cmd, .ddr_addr, .ddr_wdata, .cmd_done, .ddr_rdata,
    .awaddr, .awlen, .awsize, .awvalid, .awready,
    .wdata, .wstrb, .wlast, .wvalid, .wready,
    .bresp, .bvalid, .bready,
    .araddr, .arlen, .arsize, .arvalid, .arready,
    .rdata, .rresp, .rlast, .rvalid, .rready,
    .chan_valid, .chan_ready, .hs_status
  );

  // One stall monitor per channel, in axi_chan_e order
  for (genvar i = 0; i < `N_CHAN; i++) begin : gen_mon
    chan_timeout_mon mon_i (
      .aclk     (aclk),
      .areset   (areset),
      .valid    (chan_valid[i]),
      .ready    (chan_ready[i]),
      .tmout_us (tmout_us),
      .tmout    (chan_tmout[i])
    );
  end

endmodule

/* dv/tb_hpi2axi.sv */
//----------------------------------------------------------------------
// Testbench for the host-to-AXI bridge. Reads dv/hpi_cases.txt from the
// project root. A reactive slave memory of 256 beats answers with random
// delays of 0 to 3 cycles and keeps the low 32 bits of each beat.
//----------------------------------------------------------------------
`include "hpi_axi_macros.svh"

module tb_hpi2axi
  import hpi_reg_pkg::*;
  import axi_chan_pkg::*;
();

  logic                     aclk;
  logic                     areset;
  logic                     cpu_wr;
  logic [`HPI_ADDR_W-1:0]   cpu_addr;
  logic [`HPI_DATA_W/8-1:0] cpu_wr_strb;
  reg_word_t                cpu_data_in;
  reg_word_t                cpu_data_out;
  axi_addr_t                awaddr;
  logic [7:0]               awlen;
  logic [2:0]               awsize;
  logic                     awvalid;
  logic                     awready;
  axi_data_t                wdata;
  logic [63:0]              wstrb;
  logic                     wlast;
  logic                     wvalid;
  logic                     wready;
  axi_resp_e                bresp;
  logic                     bvalid;
  logic                     bready;
  axi_addr_t                araddr;
  logic [7:0]               arlen;
  logic [2:0]               arsize;
  logic                     arvalid;
  logic                     arready;
  axi_data_t                rdata;
  axi_resp_e                rresp;
  logic                     rlast;
  logic                     rvalid;
  logic                     rready;

  // Slave model state
  reg_word_t   mem [256];
  logic        stall_aw;
  int unsigned lcg_state;
  int          aw_cnt;
  int          w_cnt;
  int          ar_cnt;
  int          b_cnt;
  int          r_cnt;
  logic        aw_got;
  logic        w_got;
  logic        ar_got;
  logic        b_pend;
  logic        awvalid_p;
  logic        wvalid_p;
  logic        arvalid_p;
  logic        bready_p;
  logic        rready_p;
  axi_addr_t   awaddr_p;
  axi_addr_t   araddr_p;
  axi_addr_t   aw_cap;
  axi_addr_t   ar_cap;
  reg_word_t   wdata_p;
  reg_word_t   w_cap;
  logic [10:0] aw_attr_p;
  logic [10:0] ar_attr_p;
  logic [63:0] wstrb_p;
  logic        wlast_p;
  logic [10:0] aw_attr_cap;
  logic [10:0] ar_attr_cap;
  logic [63:0] wstrb_cap;
  logic        wlast_cap;

  // Case table and bookkeeping
  string     case_name[$];
  string     case_kind[$];
  reg_word_t case_addr[$];
  reg_word_t case_data[$];
  reg_word_t case_exp[$];
  int        stall_budget = 0;
  int        errors = 0;
  int        n_pass = 0;
  int        n_fail = 0;
  logic      test_ok;
  int        cycle_cnt = 0;
  int        cycle_limit = 1000;

  hpi2axi_bridge dut_i (.*);

  initial begin
    aclk = 1'b0;
    forever #50 aclk = ~aclk;
  end

  always @(posedge aclk) begin
    cycle_cnt++;
    if (cycle_cnt > cycle_limit) begin
      $display("Timeout: the run did not end within %0d cycles", cycle_limit);
      $display("RESULT: FAIL");
      $finish;
    end
  end

  // Delay of 0 to 3 cycles from a linear congruential generator
  function automatic int rand_delay();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return int'(lcg_state[17:16]);
  endfunction

  function automatic logic [7:0] beat_index(axi_addr_t addr);
    return addr[`AXI_BEAT_SHIFT +: 8];
  endfunction

  function automatic logic [`HPI_ADDR_W-1:0] host_addr(logic [11:0] ofs);
    return {`HPI_BLOCK_ID, ofs};
  endfunction

  //--------------------------------------------------------------------
  // Reactive AXI slave, driven on the falling edge
  //--------------------------------------------------------------------
  always @(negedge aclk) begin
    if (areset) begin
      // The generator restarts from its seed on every reset cycle
      lcg_state = 51;
      awready   = 1'b0;
      wready    = 1'b0;
      arready   = 1'b0;
      bvalid    = 1'b0;
      rvalid    = 1'b0;
      rlast     = 1'b0;
      aw_got    = 1'b0;
      w_got     = 1'b0;
      ar_got    = 1'b0;
      b_pend    = 1'b0;
      awvalid_p = 1'b0;
      wvalid_p  = 1'b0;
      arvalid_p = 1'b0;
      aw_cnt    = rand_delay();
      w_cnt     = rand_delay();
      ar_cnt    = rand_delay();
    end else begin
      // Handshakes taken at the rising edge just passed
      if (awvalid_p && awready) begin
        aw_cap      = awaddr_p;
        aw_attr_cap = aw_attr_p;
        aw_got      = 1'b1;
        aw_cnt      = rand_delay();
      end
      if (wvalid_p && wready) begin
        w_cap     = wdata_p;
        wstrb_cap = wstrb_p;
        wlast_cap = wlast_p;
        w_got     = 1'b1;
        w_cnt     = rand_delay();
      end
      if (arvalid_p && arready) begin
        ar_cap      = araddr_p;
        ar_attr_cap = ar_attr_p;
        ar_got      = 1'b1;
        ar_cnt      = rand_delay();
        r_cnt       = rand_delay();
      end
      if (bvalid && bready_p) begin
        bvalid = 1'b0;
      end
      if (rvalid && rready_p) begin
        rvalid = 1'b0;
        rlast  = 1'b0;
      end
      // A write lands in memory once both address and data are in
      if (aw_got && w_got) begin
        mem[beat_index(aw_cap)] = w_cap;
        aw_got = 1'b0;
        w_got  = 1'b0;
        b_pend = 1'b1;
        b_cnt  = rand_delay();
      end
      awready = 1'b0;
      if (awvalid && !stall_aw) begin
        if (aw_cnt == 0) begin
          awready = 1'b1;
        end else begin
          aw_cnt--;
        end
      end
      wready = 1'b0;
      if (wvalid) begin
        if (w_cnt == 0) begin
          wready = 1'b1;
        end else begin
          w_cnt--;
        end
      end
      arready = 1'b0;
      if (arvalid) begin
        if (ar_cnt == 0) begin
          arready = 1'b1;
        end else begin
          ar_cnt--;
        end
      end
      if (b_pend) begin
        if (b_cnt == 0) begin
          bvalid = 1'b1;
          bresp  = RESP_OKAY;
          b_pend = 1'b0;
        end else begin
          b_cnt--;
        end
      end
      if (ar_got) begin
        if (r_cnt == 0) begin
          rvalid = 1'b1;
          rlast  = 1'b1;
          rresp  = RESP_OKAY;
          rdata  = axi_data_t'(mem[beat_index(ar_cap)]);
          ar_got = 1'b0;
        end else begin
          r_cnt--;
        end
      end
      awvalid_p = awvalid;
      wvalid_p  = wvalid;
      arvalid_p = arvalid;
      bready_p  = bready;
      rready_p  = rready;
      awaddr_p  = awaddr;
      araddr_p  = araddr;
      wdata_p   = wdata[`HPI_DATA_W-1:0];
      aw_attr_p = {awlen, awsize};
      ar_attr_p = {arlen, arsize};
      wstrb_p   = wstrb;
      wlast_p   = wlast;
    end
  end

  //--------------------------------------------------------------------
  // Host register access, called on a falling edge
  //--------------------------------------------------------------------
  task automatic reg_write(logic [`HPI_ADDR_W-1:0] addr, reg_word_t data);
    cpu_wr      = 1'b1;
    cpu_addr    = addr;
    cpu_data_in = data;
    @(negedge aclk);
    cpu_wr = 1'b0;
  endtask

  task automatic reg_read(logic [`HPI_ADDR_W-1:0] addr, output reg_word_t data);
    cpu_addr = addr;
    @(negedge aclk);
    data = cpu_data_out;
  endtask

  task automatic check_word(string name, reg_word_t exp, reg_word_t act);
    if (act !== exp) begin
      $display("CHECK FAILED %s expected %08h actual %08h", name, exp, act);
      errors++;
      test_ok = 1'b0;
    end
  endtask

  task automatic check_addr(string name, axi_addr_t exp, axi_addr_t act);
    if (act !== exp) begin
      $display("CHECK FAILED %s expected %016h actual %016h", name, exp, act);
      errors++;
      test_ok = 1'b0;
    end
  endtask

  task automatic check_strb(string name, logic [63:0] exp, logic [63:0] act);
    if (act !== exp) begin
      $display("CHECK FAILED %s expected %016h actual %016h", name, exp, act);
      errors++;
      test_ok = 1'b0;
    end
  endtask

  // Polls the command register until the bridge has finished
  task automatic wait_idle(string name);
    reg_word_t val;
    int        polls;
    polls = 0;
    do begin
      reg_read(host_addr(REG_CMD), val);
      polls++;
    end while (val != reg_word_t'(CMD_IDLE) && polls < 300);
    if (val != reg_word_t'(CMD_IDLE)) begin
      $display("%s: the command did not return to idle after %0d polls", name, polls);
      errors++;
      test_ok = 1'b0;
    end
  endtask

  task automatic mem_command(reg_word_t addr, reg_word_t data, ddr_cmd_e op, string name);
    reg_write(host_addr(REG_ADDR), addr);
    if (op == CMD_WRITE) begin
      reg_write(host_addr(REG_WDATA), data);
    end
    reg_write(host_addr(REG_CMD), reg_word_t'(op));
    wait_idle(name);
  endtask

  // The stall flag changes between a rising and a falling edge
  task automatic set_stall(logic on);
    @(posedge aclk);
    stall_aw = on;
    @(negedge aclk);
  endtask

  task automatic load_cases();
    int        fd;
    string     tok;
    string     kind;
    string     rest;
    reg_word_t a;
    reg_word_t d;
    reg_word_t e;
    fd = $fopen("dv/hpi_cases.txt", "r");
    if (fd == 0) begin
      $display("Cannot open the case file dv/hpi_cases.txt");
      errors++;
    end else begin
      while ($fscanf(fd, "%s", tok) == 1) begin
        if (tok.substr(0, 0) == "#") begin
          void'($fgets(rest, fd));
        end else if ($fscanf(fd, "%s %h %h %h", kind, a, d, e) == 4) begin
          case_name.push_back(tok);
          case_kind.push_back(kind);
          case_addr.push_back(a);
          case_data.push_back(d);
          case_exp.push_back(e);
          if (kind == "STALL") stall_budget += int'(d);
        end else begin
          $display("Case %s in the case file has missing fields", tok);
          errors++;
        end
      end
      $fclose(fd);
    end
  endtask

  task automatic run_case(int i);
    string     name;
    string     kind;
    reg_word_t a;
    reg_word_t d;
    reg_word_t e;
    reg_word_t val;
    name    = case_name[i];
    kind    = case_kind[i];
    a       = case_addr[i];
    d       = case_data[i];
    e       = case_exp[i];
    test_ok = 1'b1;
    if (kind == "REGW") begin
      reg_write(a[`HPI_ADDR_W-1:0], d);
      reg_read(a[`HPI_ADDR_W-1:0], val);
      check_word(name, e, val);
    end else if (kind == "REGR") begin
      reg_read(a[`HPI_ADDR_W-1:0], val);
      check_word(name, e, val);
    end else if (kind == "MEMW") begin
      mem_command(a, d, CMD_WRITE, name);
      check_word(name, e, mem[a[7:0]]);
      check_addr(name, axi_addr_t'(a) * 64'd64, aw_cap);
      // A single 64-byte beat has len 0 and size code 6 and sets every strobe
      check_word(name, 32'h6, reg_word_t'(aw_attr_cap));
      check_strb(name, {64{1'b1}}, wstrb_cap);
      check_word(name, 32'h1, reg_word_t'(wlast_cap));
    end else if (kind == "MEMR") begin
      mem_command(a, d, CMD_READ, name);
      reg_read(host_addr(REG_RDATA), val);
      check_word(name, e, val);
      check_addr(name, axi_addr_t'(a) * 64'd64, ar_cap);
      check_word(name, 32'h6, reg_word_t'(ar_attr_cap));
    end else if (kind == "STALL") begin
      // AW is held off long enough for the monitor to expire
      reg_write(host_addr(REG_ADDR), a);
      set_stall(1'b1);
      reg_write(host_addr(REG_CMD), reg_word_t'(CMD_WRITE));
      repeat (d) @(negedge aclk);
      reg_read(host_addr(REG_TMOUT_ERR), val);
      check_word(name, e, val);
      set_stall(1'b0);
      wait_idle(name);
    end else begin
      $display("Test %s has an unknown kind %s", name, kind);
      errors++;
      test_ok = 1'b0;
    end
    if (test_ok) begin
      n_pass++;
      $display("Test %s passed", name);
    end else begin
      n_fail++;
      $display("Test %s failed", name);
    end
  endtask

  initial begin
    areset      = 1'b1;
    cpu_wr      = 1'b0;
    cpu_addr    = '0;
    cpu_wr_strb = '1;
    cpu_data_in = '0;
    awready     = 1'b0;
    wready      = 1'b0;
    bresp       = RESP_OKAY;
    bvalid      = 1'b0;
    arready     = 1'b0;
    rdata       = '0;
    rresp       = RESP_OKAY;
    rlast       = 1'b0;
    rvalid      = 1'b0;
    stall_aw    = 1'b0;
    mem         = '{default: '0};
    load_cases();
    cycle_limit = 400 * case_name.size() + stall_budget;
    repeat (2) @(posedge aclk);
    @(negedge aclk);
    areset = 1'b0;
    for (int i = 0; i < case_name.size(); i++) begin
      run_case(i);
    end
    $display("Tests run %0d, passed %0d, failed %0d", case_name.size(), n_pass, n_fail);
    if (errors == 0 && case_name.size() > 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

/* dv/hpi_cases.txt */
# Columns: name kind addr data expected, numbers in hex
# addr is the host address for REGW and REGR, the memory word for MEMW, MEMR and STALL
# STALL holds awready low for data cycles and then expects REG_TMOUT_ERR
rst_tmout_cfg  REGR   018004 0        ffff
rst_status     REGR   018100 0        41
addr_rb        REGW   018001 0000002a 2a
wdata_rb       REGW   018002 cafef00d cafef00d
tmout_cfg_rb   REGW   018004 1234     1234
unmapped_rd    REGR   018005 0        0
unmapped_hi    REGR   018200 0        0
foreign_blk    REGR   019001 0        0
memw_a         MEMW   10     11223344 11223344
memw_b         MEMW   a5     deadbeef deadbeef
memr_a         MEMR   10     0        11223344
memr_b         MEMR   a5     0        deadbeef
memr_blank     MEMR   33     0        0
memw_over      MEMW   10     5a5a0001 5a5a0001
memr_over      MEMR   10     0        5a5a0001
status_clr     REGW   018081 3ff      0
memw_status    MEMW   20     0badcafe 0badcafe
status_wr_bits REGR   018081 0        fc
status_clr2    REGW   018081 3ff      0
tmout_cfg_2    REGW   018004 2        2
tmout_aw       STALL  40     1f4      1
tmout_clr      REGW   018080 1        0
memr_stalled   MEMR   40     0        0badcafe
idle_status    REGR   018100 0        0

/* tb.f */
+incdir+include
rtl/hpi_reg_pkg.sv
rtl/axi_chan_pkg.sv
rtl/chan_timeout_mon.sv
rtl/hpi_reg_bank.sv
rtl/axi_single_master.sv
rtl/hpi2axi_bridge.sv
dv/tb_hpi2axi.sv

/* run.sh */
#!/bin/sh
# Builds the bridge testbench with Verilator and runs it from the project root
cd "$(dirname "$0")" || exit 1
verilator --binary --top-module tb_hpi2axi -f tb.f -o sim_hpi2axi \
  || { echo "Verilator build failed"; exit 1; }
out=$(./obj_dir/sim_hpi2axi) \
  || { echo "$out"; echo "Simulation exited with an error"; exit 1; }
echo "$out"
echo "$out" | grep -qx "RESULT: PASS" && exit 0 || exit 1
